// ==== design/silencer_settings.svh ====
// build-time constants for the silencer
// transducer count and field widths
`ifndef SILENCER_SETTINGS_SVH
`define SILENCER_SETTINGS_SVH

`default_nettype none

`define SILENCER_DEPTH 249          // transducers per frame
`define SILENCER_INTENSITY_W 16
`define SILENCER_PHASE_W 8          // input phase, 256 per turn
`define SILENCER_PHASE_FIXED_W 16   // fixed-point phase, 65536 per turn
`define SILENCER_RATE_W 16

`default_nettype wire

`endif

// ==== design/silencer_pkg.sv ====
// silencer_pkg
// typedefs for drive values, phase, rates and transducer index
// FSM state enum of the step calculator
`include "silencer_settings.svh"

`default_nettype none

package silencer_pkg;

  typedef logic [`SILENCER_INTENSITY_W-1:0] intensity_t;

  // one full turn is 256 here
  typedef logic [`SILENCER_PHASE_W-1:0] phase_t;
  // input phase sits in the upper byte
  typedef logic [`SILENCER_PHASE_FIXED_W-1:0] phase_fixed_t;

  typedef logic [`SILENCER_RATE_W-1:0] rate_t;  // max change per frame

  typedef logic [$clog2(`SILENCER_DEPTH)-1:0] trans_idx_t;

  typedef enum logic {
    WAITING,
    RUN_FIXED
  } step_state_t;

endpackage

`default_nettype wire

// ==== design/silencer_step_if.sv ====
// silencer_step_if
// one target beat from step calculator to interpolator
`default_nettype none

interface silencer_step_if;
  import silencer_pkg::*;

  logic         valid;
  intensity_t   target_intensity;
  phase_fixed_t target_phase;
  rate_t        rate_intensity;
  rate_t        rate_phase;

  modport src (output valid, target_intensity, target_phase, rate_intensity, rate_phase);

  modport dst (input valid, target_intensity, target_phase, rate_intensity, rate_phase);

endinterface

`default_nettype wire

// ==== design/step_calculator.sv ====
// step_calculator
// buffers each streamed target one cycle and replays the frame
// as a beat stream with widened phase and fixed update rates
`include "silencer_settings.svh"

`default_nettype none

module step_calculator (
  input  var logic                     CLK,
  input  var logic                     arst_n,
  input  var logic                     din_valid,
  input  var silencer_pkg::intensity_t intensity_in,
  input  var silencer_pkg::phase_t     phase_in,
  input  var silencer_pkg::rate_t      update_rate_intensity,
  input  var silencer_pkg::rate_t      update_rate_phase,
  silencer_step_if.src                 step
);
  import silencer_pkg::*;

  // zero bits below the input phase
  localparam int PAD_W = `SILENCER_PHASE_FIXED_W - `SILENCER_PHASE_W;

  step_state_t state;
  trans_idx_t  set_cnt;      // beats sent in this frame
  intensity_t  intensity_buf;
  phase_t      phase_buf;

  always_ff @(posedge CLK) begin
    intensity_buf <= intensity_in;  // one-cycle target buffer
    phase_buf     <= phase_in;
  end

  // frame FSM
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state      <= WAITING;
      set_cnt    <= '0;
      step.valid <= 1'b0;
    end else begin
      case (state)
        WAITING: begin
          step.valid <= 1'b0;
          if (din_valid) begin
            set_cnt <= '0;
            state   <= RUN_FIXED;
          end
        end
        RUN_FIXED: begin
          step.valid <= 1'b1;
          set_cnt    <= set_cnt + trans_idx_t'(1);
          if (set_cnt == trans_idx_t'(`SILENCER_DEPTH - 1)) begin
            state <= WAITING;  // last transducer goes out now
          end
        end
        default: begin
          state <= WAITING;
        end
      endcase
    end
  end

  // beat payload, only loaded while replaying
  always_ff @(posedge CLK) begin
    if (state == RUN_FIXED) begin
      step.target_intensity <= intensity_buf;
      step.target_phase     <= {phase_buf, {PAD_W{1'b0}}};
      step.rate_intensity   <= update_rate_intensity;
      step.rate_phase       <= update_rate_phase;
    end
  end

endmodule

`default_nettype wire

// ==== design/silencer_interpolator.sv ====
// silencer_interpolator
// current intensity and phase store, one entry per transducer
// rate-limited step toward target, phase along the short way round
`include "silencer_settings.svh"

`default_nettype none

module silencer_interpolator (
  input  var logic                     CLK,
  input  var logic                     arst_n,
  silencer_step_if.dst                 step,
  output var logic                     dout_valid,
  output var silencer_pkg::intensity_t intensity_out,
  output var silencer_pkg::phase_t     phase_out
);
  import silencer_pkg::*;

  localparam int DEPTH = `SILENCER_DEPTH;
  localparam int PW    = `SILENCER_PHASE_FIXED_W;

  intensity_t   cur_intensity [DEPTH];
  phase_fixed_t cur_phase     [DEPTH];
  trans_idx_t   idx;          // beat index within the frame

  intensity_t   cur_i;
  intensity_t   next_i;
  intensity_t   diff_i;       // absolute intensity difference
  logic         up_i;

  phase_fixed_t cur_p;
  phase_fixed_t next_p;
  phase_fixed_t diff_p;       // tgt - cur mod 65536
  logic [PW:0]  mag_p;        // |diff_p| as signed, 32768 fits
  logic         neg_p;

  assign cur_i = cur_intensity[idx];
  assign cur_p = cur_phase[idx];

  // intensity moves linearly
  always_comb begin
    up_i = (step.target_intensity >= cur_i);
    if (up_i) begin
      diff_i = step.target_intensity - cur_i;
    end else begin
      diff_i = cur_i - step.target_intensity;
    end
    if (diff_i <= step.rate_intensity) begin
      next_i = step.target_intensity;  // close enough, snap
    end else if (up_i) begin
      next_i = cur_i + step.rate_intensity;
    end else begin
      next_i = cur_i - step.rate_intensity;
    end
  end

  // phase takes the shorter way around the circle
  always_comb begin
    diff_p = step.target_phase - cur_p;
    neg_p  = diff_p[PW-1];
    if (neg_p) begin
      mag_p = {1'b0, ~diff_p} + (PW+1)'(1);
    end else begin
      mag_p = {1'b0, diff_p};
    end
    if (mag_p <= {1'b0, step.rate_phase}) begin
      next_p = step.target_phase;
    end else if (neg_p) begin
      next_p = cur_p - step.rate_phase;  // wraps below zero
    end else begin
      next_p = cur_p + step.rate_phase;
    end
  end

  // store and beat index
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      idx        <= '0;
      dout_valid <= 1'b0;
      for (int i = 0; i < DEPTH; i++) begin
        cur_intensity[i] <= '0;
        cur_phase[i]     <= '0;
      end
    end else begin
      dout_valid <= step.valid;
      if (step.valid) begin
        idx                <= idx + trans_idx_t'(1);
        cur_intensity[idx] <= next_i;
        cur_phase[idx]     <= next_p;
      end else begin
        idx <= '0;  // realign at frame gap
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (step.valid) begin
      intensity_out <= next_i;
      phase_out     <= next_p[PW-1 -: `SILENCER_PHASE_W];  // upper byte only
    end
  end

endmodule

`default_nettype wire

// ==== design/silencer.sv ====
// silencer top level
// step calculator feeding the interpolator over the beat interface
`default_nettype none

module silencer (
  input  var logic                     CLK,
  input  var logic                     arst_n,
  input  var logic                     din_valid,
  input  var silencer_pkg::intensity_t intensity_in,
  input  var silencer_pkg::phase_t     phase_in,
  input  var silencer_pkg::rate_t      update_rate_intensity,
  input  var silencer_pkg::rate_t      update_rate_phase,
  output var logic                     dout_valid,
  output var silencer_pkg::intensity_t intensity_out,
  output var silencer_pkg::phase_t     phase_out
);

  // target beats, two cycles behind the input stream
  silencer_step_if step ();

  step_calculator u_step_calculator (
    .CLK                   (CLK),
    .arst_n                (arst_n),
    .din_valid             (din_valid),
    .intensity_in          (intensity_in),
    .phase_in              (phase_in),
    .update_rate_intensity (update_rate_intensity),
    .update_rate_phase     (update_rate_phase),
    .step                  (step.src)
  );

  // one more cycle to the outputs
  silencer_interpolator u_interpolator (
    .CLK           (CLK),
    .arst_n        (arst_n),
    .step          (step.dst),
    .dout_valid    (dout_valid),
    .intensity_out (intensity_out),
    .phase_out     (phase_out)
  );

endmodule

`default_nettype wire

// ==== bench/silencer_asserts.sv ====
// silencer_asserts
// beat stream and output valid properties, bound into the top
`include "silencer_settings.svh"

`default_nettype none

module silencer_asserts (
  input var logic CLK,
  input var logic arst_n,
  input var logic step_valid,
  input var logic dout_valid
);
  timeunit 1ns;
  timeprecision 1ps;

  int run_len;         // cycles in the current valid run
  int fail_count = 0;  // failed assertions so far

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      run_len <= 0;
    end else if (step_valid) begin
      run_len <= run_len + 1;
    end else begin
      run_len <= 0;
    end
  end

  follow_a: assert property (@(posedge CLK) disable iff (!arst_n)
    dout_valid == $past(step_valid))
    else begin
      fail_count++;
      $error("dout_valid is not step valid delayed by one cycle");
    end

  // a run ends after exactly one frame of beats
  run_end_a: assert property (@(posedge CLK) disable iff (!arst_n)
    $fell(step_valid) |-> run_len == `SILENCER_DEPTH)
    else begin
      fail_count++;
      $error("step valid run ended after %0d beats", $sampled(run_len));
    end

  run_max_a: assert property (@(posedge CLK) disable iff (!arst_n)
    step_valid |-> run_len < `SILENCER_DEPTH)
    else begin
      fail_count++;
      $error("step valid run longer than one frame");
    end

  reset_a: assert property (@(posedge CLK) !arst_n |-> !dout_valid)
    else begin
      fail_count++;
      $error("dout_valid high during reset");
    end

endmodule

bind silencer silencer_asserts u_asserts (
  .CLK        (CLK),
  .arst_n     (arst_n),
  .step_valid (step.valid),
  .dout_valid (dout_valid)
);

`default_nettype wire

// ==== bench/silencer_tb.sv ====
// silencer_tb
// clock, reset, LCG stimulus and a reference model of the silencer
// output checks, per-test report and a cycle timeout
`include "silencer_settings.svh"

`default_nettype none

module silencer_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import silencer_pkg::*;

  localparam int DEPTH      = `SILENCER_DEPTH;
  localparam int NUM_FRAMES = 23;  // frames sent over all tests
  localparam int MAX_CYCLES = NUM_FRAMES * (DEPTH + 10) + 100;

  logic CLK = 1'b0;
  logic arst_n;
  logic din_valid;
  logic dout_valid;
  intensity_t intensity_in;
  intensity_t intensity_out;
  phase_t     phase_in;
  phase_t     phase_out;
  rate_t      update_rate_intensity;
  rate_t      update_rate_phase;

  logic [31:0] seed = 32'd41;
  int cycle = 0;
  int errors = 0;
  int checks = 0;
  int out_count = 0;
  int errs_mark = 0;
  int rate_i;
  int rate_p;
  int tgt_i[];   // frame targets, phase in input units
  int tgt_p[];
  int model_i[];  // model current values, phase in 16-bit fixed point
  int model_p[];
  int last_i[];  // last DUT output per transducer
  int last_p[];
  int exp_i[$];
  int exp_p[$];
  int exp_idx[$];
  int exp_rate[$];
  int exp_cyc[$];

  silencer u_dut (
    .CLK                   (CLK),
    .arst_n                (arst_n),
    .din_valid             (din_valid),
    .intensity_in          (intensity_in),
    .phase_in              (phase_in),
    .update_rate_intensity (update_rate_intensity),
    .update_rate_phase     (update_rate_phase),
    .dout_valid            (dout_valid),
    .intensity_out         (intensity_out),
    .phase_out             (phase_out)
  );

  always #50 CLK = ~CLK;

  always @(posedge CLK) cycle <= cycle + 1;

  always @(posedge CLK) begin
    if (cycle >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles, outputs still missing", cycle);
      $display("sim failed");
      $finish;
    end
  end

  function automatic int next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return int'(seed[31:16]);  // 0 to 65535
  endfunction

  function automatic int step_intensity(int cur, int tgt, int rate);
    int diff;
    diff = tgt - cur;
    if (diff <= rate && diff >= -rate) return tgt;
    return (diff > 0) ? cur + rate : cur - rate;
  endfunction

  function automatic int step_phase(int cur, int tgt, int rate);
    int diff;
    diff = (tgt - cur) & 32'hffff;
    if (diff >= 32768) diff = diff - 65536;  // signed, short way round
    if (diff <= rate && diff >= -rate) return tgt;
    return (diff > 0) ? (cur + rate) & 32'hffff : (cur - rate) & 32'hffff;
  endfunction

  task automatic check_equal(input string what, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // model first, so expected values are queued before outputs appear
  task automatic send_frame(input bit mid_pulse);
    for (int k = 0; k < DEPTH; k++) begin
      model_i[k] = step_intensity(model_i[k], tgt_i[k], rate_i);
      model_p[k] = step_phase(model_p[k], tgt_p[k] * 256, rate_p);
      exp_i.push_back(model_i[k]);
      exp_p.push_back(model_p[k] / 256);
      exp_idx.push_back(k);
      exp_rate.push_back(rate_i);
    end
    for (int k = 0; k < DEPTH; k++) begin
      @(posedge CLK);
      din_valid    <= (k == 0) || (mid_pulse && k == DEPTH / 2);
      intensity_in <= 16'(tgt_i[k]);
      phase_in     <= 8'(tgt_p[k]);
      if (k == 0) begin
        update_rate_intensity <= 16'(rate_i);
        update_rate_phase     <= 16'(rate_p);
      end
      exp_cyc.push_back(cycle + 4);  // edge number plus 3
    end
    @(posedge CLK);
    din_valid <= 1'b0;  // gap cycle, next frame may start after it
  endtask

  task automatic random_targets();
    for (int k = 0; k < DEPTH; k++) begin
      tgt_i[k] = next_rand();
      tgt_p[k] = next_rand() % 256;
    end
  endtask

  task automatic release_reset();
    repeat (8) @(posedge CLK);
    arst_n <= 1'b1;
  endtask

  task automatic wait_drained();
    while (exp_i.size() != 0) @(negedge CLK);
    @(posedge CLK);
  endtask

  task automatic check_reached();
    for (int k = 0; k < DEPTH; k++) begin
      check_equal($sformatf("transducer %0d intensity at target", k), last_i[k], tgt_i[k]);
      check_equal($sformatf("transducer %0d phase at target", k), last_p[k], tgt_p[k]);
    end
  endtask

  task automatic report_test(input string name);
    $display("%s: done, %0d errors", name, errors - errs_mark);
    errs_mark = errors;
  endtask

  // outputs are stable at the falling edge
  always @(negedge CLK) begin
    int idx;
    int moved;
    if (dout_valid === 1'b1) begin
      if (exp_i.size() == 0) begin
        errors++;
        $display("output seen at %0t while no frame was pending", $time);
      end else begin
        idx   = exp_idx.pop_front();
        moved = int'(intensity_out) - last_i[idx];
        if (moved < 0) moved = -moved;
        check_equal("intensity step within rate", int'(moved <= exp_rate.pop_front()), 1);
        check_equal("intensity_out", int'(intensity_out), exp_i.pop_front());
        check_equal("phase_out", int'(phase_out), exp_p.pop_front());
        check_equal("output cycle", cycle, exp_cyc.pop_front());
        last_i[idx] = int'(intensity_out);
        last_p[idx] = int'(phase_out);
        out_count++;
      end
    end
  end

  initial begin
    din_valid             = 1'b0;
    intensity_in          = '0;
    phase_in              = '0;
    update_rate_intensity = '0;
    update_rate_phase     = '0;
    arst_n                = 1'b1;
    tgt_i   = new[DEPTH];
    tgt_p   = new[DEPTH];
    model_i = new[DEPTH];
    model_p = new[DEPTH];
    last_i  = new[DEPTH];
    last_p  = new[DEPTH];
    #10 arst_n = 1'b0;
    release_reset();

    // idle after reset, then a full-rate frame lands on target
    repeat (4) @(negedge CLK);
    check_equal("dout_valid low before first frame", int'(dout_valid === 1'b0), 1);
    random_targets();
    rate_i = 65535;
    rate_p = 65535;
    send_frame(1'b0);
    wait_drained();
    check_reached();
    report_test("test 1 reset and full-rate frame");

    random_targets();
    rate_i = 8192 + next_rand() % 4096;  // at most 8 frames to converge
    rate_p = 4096 + next_rand() % 4096;
    repeat (9) send_frame(1'b0);
    wait_drained();
    check_reached();
    report_test("test 2 slow rates converge");

    // start near 250, then step forward through 0
    for (int k = 0; k < DEPTH; k++) tgt_p[k] = 250 + next_rand() % 3;
    rate_p = 65535;
    send_frame(1'b0);
    for (int k = 0; k < DEPTH; k++) tgt_p[k] = 3 + next_rand() % 3;
    rate_p = 768;  // 3 input steps per frame
    repeat (4) send_frame(1'b0);
    wait_drained();
    check_reached();
    report_test("test 3 phase wraparound");

    random_targets();
    rate_i = next_rand();
    rate_p = next_rand();
    repeat (2) send_frame(1'b1);
    wait_drained();
    report_test("test 4 mid-frame din_valid ignored");

    repeat (6) begin
      random_targets();
      rate_i = next_rand();
      rate_p = next_rand();
      send_frame(1'b0);
    end
    wait_drained();
    report_test("test 5 back-to-back frames");

    check_equal("output count", out_count, NUM_FRAMES * DEPTH);
    check_equal("failed assertions", u_dut.u_asserts.fail_count, 0);
    $display("%0d checks, %0d errors, %0d outputs", checks, errors, out_count);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+design
design/silencer_pkg.sv
design/silencer_step_if.sv
design/step_calculator.sv
design/silencer_interpolator.sv
design/silencer.sv
bench/silencer_asserts.sv
bench/silencer_tb.sv

// ==== Makefile ====
# Verilator build and run for the silencer testbench

VERILATOR ?= verilator
TOP       ?= silencer_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
